/* logic/icache_pkg.sv */
package icache_pkg;

    // Byte address and word geometry.
    localparam int ADDR_WIDTH = 32;
    localparam int WORD_WIDTH = 32;

    // One line holds LINE_WORDS words, fetched as one burst of LINE_WORDS beats.
    localparam int LINE_WORDS   = 4;
    localparam int OFFSET_WIDTH = 2;

    localparam int SETS        = 16;
    localparam int INDEX_WIDTH = 4;
    localparam int WAYS        = 4;

    // Tag is what is left above index, word offset and the two byte bits.
    localparam int TAG_WIDTH = ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH - 2;

    // Binary tree over the ways: one root bit and one bit per pair.
    localparam int PLRU_BITS = WAYS - 1;

    typedef enum logic [2:0] {
        state_idle,
        state_lookup,
        state_miss,
        state_refill,
        state_fence
    } cache_state_t;

endpackage

/* logic/icache_way.sv */
`timescale 1ns/10ps

module icache_way (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                rd_en,
    input  logic [icache_pkg::INDEX_WIDTH-1:0]  rd_index,
    input  logic [icache_pkg::OFFSET_WIDTH-1:0] rd_offset,
    input  logic [icache_pkg::TAG_WIDTH-1:0]    lookup_tag,
    input  logic                                wr_en,
    input  logic [icache_pkg::INDEX_WIDTH-1:0]  wr_index,
    input  logic [icache_pkg::OFFSET_WIDTH-1:0] wr_offset,
    input  logic [icache_pkg::WORD_WIDTH-1:0]   wr_data,
    input  logic                                tag_we,
    input  logic                                inval_en,
    output logic                                hit,
    output logic [icache_pkg::WORD_WIDTH-1:0]   word
);
    import icache_pkg::*;

    logic [SETS-1:0]       valid;
    logic [TAG_WIDTH-1:0]  tag_mem  [SETS];
    logic [WORD_WIDTH-1:0] data_mem [SETS][LINE_WORDS];

    logic                 rd_valid;
    logic [TAG_WIDTH-1:0] rd_tag;

    // Invalidation wins over a tag write to the same set.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid    <= '0;
            rd_valid <= 1'b0;
        end else begin
            if (inval_en) begin
                valid[wr_index] <= 1'b0;
            end else if (wr_en && tag_we) begin
                valid[wr_index] <= 1'b1;
            end
            if (rd_en) begin
                rd_valid <= valid[rd_index];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            data_mem[wr_index][wr_offset] <= wr_data;
            if (tag_we) begin
                tag_mem[wr_index] <= lookup_tag;
            end
        end
        if (rd_en) begin
            rd_tag <= tag_mem[rd_index];
            word   <= data_mem[rd_index][rd_offset];
        end
    end

    // Compared against the registered request tag in the lookup cycle.
    assign hit = rd_valid && (rd_tag == lookup_tag);

endmodule

/* logic/icache_plru.sv */
`timescale 1ns/10ps

module icache_plru (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               touch_en,
    input  logic [icache_pkg::INDEX_WIDTH-1:0] touch_index,
    input  logic [icache_pkg::WAYS-1:0]        touch_way,
    input  logic [icache_pkg::INDEX_WIDTH-1:0] victim_index,
    output logic [icache_pkg::WAYS-1:0]        victim_way
);
    import icache_pkg::*;

    // Bit 0 is the root, bit 1 picks within ways 0/1, bit 2 within ways 2/3.
    logic [SETS-1:0][PLRU_BITS-1:0] tree;
    logic [PLRU_BITS-1:0]           victim_bits;
    logic                           touch_right;
    logic                           touch_odd;

    assign victim_bits = tree[victim_index];
    assign touch_right = touch_way[2] | touch_way[3];
    assign touch_odd   = touch_way[1] | touch_way[3];

    always_comb begin
        victim_way = '0;
        if (!victim_bits[0]) begin
            victim_way[{1'b0, victim_bits[1]}] = 1'b1;
        end else begin
            victim_way[{1'b1, victim_bits[2]}] = 1'b1;
        end
    end

    // Both bits on the touched path are turned to point away from it.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tree <= '0;
        end else if (touch_en) begin
            tree[touch_index][0] <= !touch_right;
            if (touch_right) begin
                tree[touch_index][2] <= !touch_odd;
            end else begin
                tree[touch_index][1] <= !touch_odd;
            end
        end
    end

endmodule

/* logic/icache_hit_select.sv */
`timescale 1ns/10ps

module icache_hit_select (
    input  logic [icache_pkg::WAYS-1:0]                            way_hit,
    input  logic [icache_pkg::WAYS-1:0][icache_pkg::WORD_WIDTH-1:0] way_word,
    output logic                                                   hit,
    output logic [icache_pkg::WAYS-1:0]                            hit_way,
    output logic [icache_pkg::WORD_WIDTH-1:0]                      word
);
    import icache_pkg::*;

    assign hit     = |way_hit;
    assign hit_way = way_hit; // At most one way holds a given tag.

    // AND-OR mux, so no priority logic is needed.
    always_comb begin
        word = '0;
        for (int w = 0; w < WAYS; w++) begin
            word = word | (way_word[w] & {WORD_WIDTH{way_hit[w]}});
        end
    end

endmodule

/* logic/icache_ctrl.sv */
`timescale 1ns/10ps

module icache_ctrl (
    input  logic                                      clk,
    input  logic                                      rst,
    input  logic                                      fetch_valid,
    input  logic [icache_pkg::ADDR_WIDTH-1:0]         fetch_addr,
    output logic                                      fetch_ready,
    output logic                                      resp_valid,
    output logic [icache_pkg::WORD_WIDTH-1:0]         resp_data,
    output logic                                      ar_valid,
    output logic [icache_pkg::ADDR_WIDTH-1:0]         ar_addr,
    input  logic                                      ar_ready,
    input  logic                                      r_valid,
    input  logic [icache_pkg::WORD_WIDTH-1:0]         r_data,
    input  logic                                      r_last,
    input  logic                                      fence_req,
    output logic                                      fence_done,
    output logic                                      rd_en,
    output logic [icache_pkg::INDEX_WIDTH-1:0]        rd_index,
    output logic [icache_pkg::OFFSET_WIDTH-1:0]       rd_offset,
    output logic [icache_pkg::TAG_WIDTH-1:0]          lookup_tag,
    output logic [icache_pkg::WAYS-1:0]               wr_way,
    output logic [icache_pkg::INDEX_WIDTH-1:0]        wr_index,
    output logic [icache_pkg::OFFSET_WIDTH-1:0]       wr_offset,
    output logic [icache_pkg::WORD_WIDTH-1:0]         wr_data,
    output logic                                      tag_we,
    output logic                                      inval_en,
    input  logic                                      hit,
    input  logic [icache_pkg::WAYS-1:0]               hit_way,
    input  logic [icache_pkg::WORD_WIDTH-1:0]         hit_word,
    input  logic [icache_pkg::WAYS-1:0]               victim_way,
    output logic                                      touch_en,
    output logic [icache_pkg::INDEX_WIDTH-1:0]        touch_index,
    output logic [icache_pkg::WAYS-1:0]               touch_way,
    output logic [icache_pkg::INDEX_WIDTH-1:0]        victim_index
);
    import icache_pkg::*;

    cache_state_t state;

    // Request register, loaded on every accepted fetch.
    logic [TAG_WIDTH-1:0]    req_tag;
    logic [INDEX_WIDTH-1:0]  req_index;
    logic [OFFSET_WIDTH-1:0] req_offset;

    // Miss buffer.
    logic [WAYS-1:0]         victim_reg;
    logic [OFFSET_WIDTH-1:0] beat_cnt;
    logic [WORD_WIDTH-1:0]   miss_buf;
    logic                    miss_resp;

    logic [INDEX_WIDTH-1:0]  fence_idx;

    logic lookup_hit;
    logic lookup_miss;
    logic refill_beat;
    logic refill_last;
    logic fence_last;

    assign lookup_hit  = (state == state_lookup) && hit;
    assign lookup_miss = (state == state_lookup) && !hit;
    assign refill_beat = (state == state_refill) && r_valid;
    assign refill_last = refill_beat && r_last;
    assign fence_last  = (state == state_fence) && (fence_idx == INDEX_WIDTH'(SETS - 1));

    // A hit frees the lookup stage, so the next fetch can overlap the response.
    assign fetch_ready = ((state == state_idle) && !fence_req) || lookup_hit;

    assign rd_en      = fetch_valid && fetch_ready;
    assign rd_index   = fetch_addr[OFFSET_WIDTH+2 +: INDEX_WIDTH];
    assign rd_offset  = fetch_addr[2 +: OFFSET_WIDTH];
    assign lookup_tag = req_tag; // Also the tag written on refill.

    assign resp_valid = lookup_hit || miss_resp;
    assign resp_data  = miss_resp ? miss_buf : hit_word;

    assign ar_valid = (state == state_miss);
    assign ar_addr  = {req_tag, req_index, {(OFFSET_WIDTH + 2){1'b0}}};

    assign wr_way    = {WAYS{refill_beat}} & victim_reg;
    assign wr_index  = (state == state_fence) ? fence_idx : req_index;
    assign wr_offset = beat_cnt;
    assign wr_data   = r_data;
    assign tag_we    = refill_last;
    assign inval_en  = (state == state_fence);

    assign touch_en     = lookup_hit || refill_last;
    assign touch_index  = req_index;
    assign touch_way    = refill_last ? victim_reg : hit_way;
    assign victim_index = req_index;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= state_idle;
            beat_cnt   <= '0;
            fence_idx  <= '0;
            miss_resp  <= 1'b0;
            fence_done <= 1'b0;
        end else begin
            case (state)
                state_idle: begin
                    if (fence_req) begin
                        state     <= state_fence;
                        fence_idx <= '0;
                    end else if (fetch_valid) begin
                        state <= state_lookup;
                    end
                end
                state_lookup: begin
                    if (!hit) begin
                        state <= state_miss;
                    end else if (!fetch_valid) begin
                        state <= state_idle;
                    end
                end
                state_miss: begin
                    if (ar_ready) begin
                        state    <= state_refill;
                        beat_cnt <= '0;
                    end
                end
                state_refill: begin
                    if (r_valid) begin
                        beat_cnt <= beat_cnt + 1'b1; // Beats arrive in word order.
                        if (r_last) begin
                            state <= state_idle;
                        end
                    end
                end
                state_fence: begin
                    fence_idx <= fence_idx + 1'b1;
                    if (fence_last) begin
                        state <= state_idle;
                    end
                end
                default: state <= state_idle;
            endcase
            miss_resp  <= refill_last;
            fence_done <= fence_last;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            req_tag    <= fetch_addr[ADDR_WIDTH-1 -: TAG_WIDTH];
            req_index  <= rd_index;
            req_offset <= rd_offset;
        end
        if (lookup_miss) begin
            victim_reg <= victim_way; // Held for the whole refill.
        end
        if (refill_beat && (beat_cnt == req_offset)) begin
            miss_buf <= r_data;
        end
    end

endmodule

/* logic/icache_top.sv */
`timescale 1ns/10ps

module icache_top (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              fetch_valid,
    input  logic [icache_pkg::ADDR_WIDTH-1:0] fetch_addr,
    output logic                              fetch_ready,
    output logic                              resp_valid,
    output logic [icache_pkg::WORD_WIDTH-1:0] resp_data,
    output logic                              ar_valid,
    output logic [icache_pkg::ADDR_WIDTH-1:0] ar_addr,
    input  logic                              ar_ready,
    input  logic                              r_valid,
    input  logic [icache_pkg::WORD_WIDTH-1:0] r_data,
    input  logic                              r_last,
    input  logic                              fence_req,
    output logic                              fence_done
);
    import icache_pkg::*;

    logic                    rd_en;
    logic [INDEX_WIDTH-1:0]  rd_index;
    logic [OFFSET_WIDTH-1:0] rd_offset;
    logic [TAG_WIDTH-1:0]    lookup_tag;
    logic [WAYS-1:0]         wr_way;
    logic [INDEX_WIDTH-1:0]  wr_index;
    logic [OFFSET_WIDTH-1:0] wr_offset;
    logic [WORD_WIDTH-1:0]   wr_data;
    logic                    tag_we;
    logic                    inval_en;

    logic [WAYS-1:0]                 way_hit;
    logic [WAYS-1:0][WORD_WIDTH-1:0] way_word;
    logic                            hit;
    logic [WAYS-1:0]                 hit_way;
    logic [WORD_WIDTH-1:0]           hit_word;

    logic                   touch_en;
    logic [INDEX_WIDTH-1:0] touch_index;
    logic [WAYS-1:0]        touch_way;
    logic [INDEX_WIDTH-1:0] victim_index;
    logic [WAYS-1:0]        victim_way;

    icache_ctrl u_ctrl (.*);

    for (genvar i = 0; i < WAYS; i++) begin : g_way
        icache_way u_way (
            .clk        (clk),
            .rst        (rst),
            .rd_en      (rd_en),
            .rd_index   (rd_index),
            .rd_offset  (rd_offset),
            .lookup_tag (lookup_tag),
            .wr_en      (wr_way[i]),
            .wr_index   (wr_index),
            .wr_offset  (wr_offset),
            .wr_data    (wr_data),
            .tag_we     (tag_we),
            .inval_en   (inval_en),
            .hit        (way_hit[i]),
            .word       (way_word[i])
        );
    end

    icache_hit_select u_hit_select (
        .way_hit  (way_hit),
        .way_word (way_word),
        .hit      (hit),
        .hit_way  (hit_way),
        .word     (hit_word)
    );

    icache_plru u_plru (
        .clk          (clk),
        .rst          (rst),
        .touch_en     (touch_en),
        .touch_index  (touch_index),
        .touch_way    (touch_way),
        .victim_index (victim_index),
        .victim_way   (victim_way)
    );

endmodule

/* tests/icache_asserts.sv */
`timescale 1ns/10ps

module icache_asserts (
    input logic                              clk,
    input logic                              rst,
    input logic                              fetch_valid,
    input logic                              fetch_ready,
    input logic                              resp_valid,
    input logic                              ar_valid,
    input logic [icache_pkg::ADDR_WIDTH-1:0] ar_addr,
    input logic                              ar_ready,
    input logic                              fence_done,
    input icache_pkg::cache_state_t          state
);
    import icache_pkg::*;

    int fail_count = 0;

    ar_hold: assert property (@(posedge clk) disable iff (rst)
        ar_valid && !ar_ready |=> ar_valid && $stable(ar_addr))
    else begin
        $error("ar_valid dropped or ar_addr moved before ar_ready");
        fail_count++;
    end

    // A second response in a row can only be a hit accepted in the cycle before.
    resp_pair: assert property (@(posedge clk) disable iff (rst)
        resp_valid && $past(resp_valid) |-> $past(fetch_valid && fetch_ready))
    else begin
        $error("Back-to-back responses without a matching accepted request");
        fail_count++;
    end

    fence_stall: assert property (@(posedge clk) disable iff (rst)
        state == state_fence |-> !fetch_ready)
    else begin
        $error("fetch_ready high while the fence walk runs");
        fail_count++;
    end

    fence_quiet: assert property (@(posedge clk) disable iff (rst)
        (state == state_fence) || fence_done |-> !resp_valid)
    else begin
        $error("Response issued during a fence");
        fail_count++;
    end

endmodule

/* tests/icache_tb.sv */
`timescale 1ns/10ps

module icache_tb;
    import icache_pkg::*;

    localparam int TIMEOUT_CYCLES = 3000; // About 50 requests of up to 15 cycles, plus a fence.
    localparam logic [WORD_WIDTH-1:0] PATTERN = 32'h5a5a0000;

    logic                  clk;
    logic                  rst;
    logic                  fetch_valid;
    logic [ADDR_WIDTH-1:0] fetch_addr;
    logic                  fetch_ready;
    logic                  resp_valid;
    logic [WORD_WIDTH-1:0] resp_data;
    logic                  ar_valid;
    logic [ADDR_WIDTH-1:0] ar_addr;
    logic                  ar_ready;
    logic                  r_valid;
    logic [WORD_WIDTH-1:0] r_data;
    logic                  r_last;
    logic                  fence_req;
    logic                  fence_done;

    int seed = 45;
    int errors = 0;
    int checks = 0;
    int tests = 0;

    // Event counters, updated like flops and read on falling edges.
    int                    cycle = 0;
    int                    bursts = 0;
    int                    accepts = 0;
    int                    resps = 0;
    int                    accept_cycle = 0;
    int                    resp_cycle = 0;
    logic [ADDR_WIDTH-1:0] last_ar_addr = '0;
    logic [WORD_WIDTH-1:0] resp_word = '0;

    icache_top dut_i (.*);

    bind icache_top icache_asserts asserts_i (
        .clk         (clk),
        .rst         (rst),
        .fetch_valid (fetch_valid),
        .fetch_ready (fetch_ready),
        .resp_valid  (resp_valid),
        .ar_valid    (ar_valid),
        .ar_addr     (ar_addr),
        .ar_ready    (ar_ready),
        .fence_done  (fence_done),
        .state       (u_ctrl.state)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (ar_valid && ar_ready) begin
            bursts       <= bursts + 1;
            last_ar_addr <= ar_addr;
        end
        if (fetch_valid && fetch_ready) begin
            accepts      <= accepts + 1;
            accept_cycle <= cycle;
        end
        if (resp_valid) begin
            resps      <= resps + 1;
            resp_cycle <= cycle;
            resp_word  <= resp_data;
        end
    end

    always @(posedge clk) begin
        if (cycle >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("*** FAILED ***");
            $finish;
        end
    end

    // Memory answers each burst with one line, word address xor PATTERN.
    initial begin : memory_model
        int                    delay;
        logic [ADDR_WIDTH-1:0] line;
        forever begin
            @(negedge clk);
            if (ar_valid) begin
                line  = ar_addr;
                delay = $random(seed) & 3;
                repeat (delay) @(negedge clk);
                ar_ready = 1'b1;
                @(negedge clk);
                ar_ready = 1'b0;
                for (int beat = 0; beat < LINE_WORDS; beat++) begin
                    r_valid = 1'b1;
                    r_data  = (line + ADDR_WIDTH'(4 * beat)) ^ PATTERN;
                    r_last  = (beat == LINE_WORDS - 1);
                    @(negedge clk);
                end
                r_valid = 1'b0;
                r_last  = 1'b0;
            end
        end
    end

    function automatic logic [ADDR_WIDTH-1:0] make_addr(input int tag, input int index,
                                                         input int offset);
        return {TAG_WIDTH'(tag), INDEX_WIDTH'(index), OFFSET_WIDTH'(offset), 2'b00};
    endfunction

    // exp_bursts is 1 for a miss, 0 for a hit and -1 where either is fine.
    task automatic fetch_and_check(input string name, input logic [ADDR_WIDTH-1:0] addr,
                                   input int exp_bursts);
        int                    bursts_before;
        int                    accepts_before;
        int                    resps_before;
        logic [WORD_WIDTH-1:0] exp_word;
        exp_word = addr ^ PATTERN;
        @(negedge clk);
        bursts_before  = bursts;
        accepts_before = accepts;
        resps_before   = resps;
        fetch_valid    = 1'b1;
        fetch_addr     = addr;
        while (accepts == accepts_before) @(negedge clk);
        fetch_valid = 1'b0;
        while (resps == resps_before) @(negedge clk);
        checks++;
        assert (resp_word == exp_word) else begin
            $display("Error %s: word at %h expected %h actual %h", name, addr,
                     exp_word, resp_word);
            errors++;
        end
        if (exp_bursts >= 0) begin
            assert (bursts - bursts_before == exp_bursts) else begin
                $display("Error %s: bursts for %h expected %0d actual %0d", name, addr,
                         exp_bursts, bursts - bursts_before);
                errors++;
            end
        end
        if (exp_bursts == 1) begin
            assert (last_ar_addr == {addr[ADDR_WIDTH-1:4], 4'h0}) else begin
                $display("Error %s: ar_addr expected %h actual %h", name,
                         {addr[ADDR_WIDTH-1:4], 4'h0}, last_ar_addr);
                errors++;
            end
        end else if (exp_bursts == 0) begin
            assert (resp_cycle - accept_cycle == 1) else begin
                $display("Error %s: hit latency expected 1 actual %0d", name,
                         resp_cycle - accept_cycle);
                errors++;
            end
        end
    endtask

    // Two cached lines; the second request is accepted while the first response leaves.
    task automatic fetch_pair_and_check(input string name,
                                        input logic [ADDR_WIDTH-1:0] addr_a,
                                        input logic [ADDR_WIDTH-1:0] addr_b);
        int                    accepts_before;
        logic [WORD_WIDTH-1:0] exp_a;
        logic [WORD_WIDTH-1:0] exp_b;
        exp_a = addr_a ^ PATTERN;
        exp_b = addr_b ^ PATTERN;
        @(negedge clk);
        accepts_before = accepts;
        fetch_valid    = 1'b1;
        fetch_addr     = addr_a;
        while (accepts == accepts_before) @(negedge clk);
        fetch_addr = addr_b; // Lookup cycle of the first request.
        checks++;
        assert (resp_valid && (resp_data == exp_a)) else begin
            $display("Error %s: first word expected %h actual %h (resp_valid %b)", name,
                     exp_a, resp_data, resp_valid);
            errors++;
        end
        @(negedge clk);
        fetch_valid = 1'b0;
        checks++;
        assert (accepts - accepts_before == 2) else begin
            $display("Error %s: accepted requests expected 2 actual %0d", name,
                     accepts - accepts_before);
            errors++;
        end
        checks++;
        assert (resp_valid && (resp_data == exp_b)) else begin
            $display("Error %s: second word expected %h actual %h (resp_valid %b)", name,
                     exp_b, resp_data, resp_valid);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests++;
        $display("Test %s finished with %0d errors", name, errors - errors_before);
    endtask

    initial begin : stimulus
        int first_err;
        int walk;
        int assert_fails;
        clk         = 1'b0;
        rst         = 1'b1;
        fetch_valid = 1'b0;
        fetch_addr  = '0;
        ar_ready    = 1'b0;
        r_valid     = 1'b0;
        r_data      = '0;
        r_last      = 1'b0;
        fence_req   = 1'b0;
        repeat (4) @(negedge clk);
        rst = 1'b0;

        first_err = errors;
        @(negedge clk);
        assert (fetch_ready && !resp_valid && !ar_valid && !fence_done) else begin
            $display("Error reset: ready/resp/ar/done expected 1000 actual %b%b%b%b",
                     fetch_ready, resp_valid, ar_valid, fence_done);
            errors++;
        end
        report_test("reset", first_err);

        first_err = errors;
        fetch_and_check("miss_then_hit", make_addr(16, 4, 0), 1);
        fetch_and_check("miss_then_hit", make_addr(16, 4, 2), 0);
        report_test("miss_then_hit", first_err);

        // Sets 0 to 7 only, so sets 9 and 15 stay untouched.
        first_err = errors;
        for (int i = 0; i < 24; i++) begin
            fetch_and_check("word_select", make_addr(48 + ($random(seed) & 1),
                            $random(seed) & 7, $random(seed) & 3), -1);
        end
        report_test("word_select", first_err);

        first_err = errors;
        for (int k = 0; k < WAYS; k++) begin
            fetch_and_check("four_way", make_addr(64 + k, 9, k), 1);
        end
        for (int k = 0; k < WAYS; k++) begin
            fetch_and_check("four_way", make_addr(64 + k, 9, 3 - k), 0);
        end
        report_test("four_way", first_err);

        first_err = errors;
        fetch_pair_and_check("back_to_back", make_addr(64, 9, 1), make_addr(67, 9, 2));
        report_test("back_to_back", first_err);

        // Lines A to E are tags 80 to 84 in set 15; A, B, C, D land in ways 0, 2, 1, 3.
        first_err = errors;
        for (int k = 0; k < WAYS; k++) begin
            fetch_and_check("victim", make_addr(80 + k, 15, 0), 1);
        end
        fetch_and_check("victim_touch_a", make_addr(80, 15, 1), 0);
        fetch_and_check("victim_fill_e", make_addr(84, 15, 2), 1);
        fetch_and_check("victim_keep_a", make_addr(80, 15, 3), 0);
        fetch_and_check("victim_keep_c", make_addr(82, 15, 1), 0);
        fetch_and_check("victim_keep_d", make_addr(83, 15, 2), 0);
        fetch_and_check("victim_evicted_b", make_addr(81, 15, 3), 1);
        report_test("victim", first_err);

        first_err = errors;
        fetch_and_check("fence_before", make_addr(16, 4, 1), 0);
        @(negedge clk);
        fence_req = 1'b1;
        @(negedge clk);
        fence_req = 1'b0;
        walk = 0;
        while (!fence_done) begin
            assert (!fetch_ready) else begin
                $display("Error fence_walk: fetch_ready expected 0 actual %b", fetch_ready);
                errors++;
            end
            walk++;
            @(negedge clk);
        end
        assert (walk == SETS) else begin
            $display("Error fence_walk: cycles expected %0d actual %0d", SETS, walk);
            errors++;
        end
        fetch_and_check("fence_after", make_addr(16, 4, 1), 1);
        report_test("fence", first_err);

        assert_fails = dut_i.asserts_i.fail_count;
        $display("Tests %0d, checks %0d, errors %0d, assertion failures %0d",
                 tests, checks, errors, assert_fails);
        if (errors == 0 && assert_fails == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

/* flist.f */
logic/icache_pkg.sv
logic/icache_way.sv
logic/icache_plru.sv
logic/icache_hit_select.sv
logic/icache_ctrl.sv
logic/icache_top.sv
tests/icache_asserts.sv
tests/icache_tb.sv

/* Makefile */
TOP = icache_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f flist.f

run: compile
	./obj_dir/V$(TOP) +verilator+error+limit+1000 | tee sim.log
	grep -q '\*\*\* PASSED \*\*\*' sim.log

clean:
	rm -rf obj_dir sim.log
